// ==== src/mlp_macros.svh ====
`ifndef MLP_MACROS_SVH
`define MLP_MACROS_SVH

// width of every data word in the network.
`define MLP_WIDTH 16

// number of input features per vector.
`define MLP_FEATURES 15

// neurons in the hidden layer.
`define MLP_HIDDEN 4

// neurons in the output layer, one per class.
`define MLP_CLASSES 3

`endif

// ==== src/mlpPkg.sv ====
`include "mlp_macros.svh"

package mlpPkg;

	// two's-complement data word, all arithmetic wraps at this width.
	typedef logic signed [`MLP_WIDTH-1:0] word_t;

	// one row of weights for a hidden or an output neuron.
	typedef word_t [`MLP_FEATURES-1:0] hiddenRow_t;
	typedef word_t [`MLP_HIDDEN-1:0] outputRow_t;

	typedef logic [$clog2(`MLP_CLASSES)-1:0] classIdx_t;

	typedef enum logic
	{
		actRelu,
		actLinear
	} actFunc_t;

	// highest feature sits in the upper bits.
	typedef struct packed
	{
		word_t feat14;
		word_t feat13;
		word_t feat12;
		word_t feat11;
		word_t feat10;
		word_t feat9;
		word_t feat8;
		word_t feat7;
		word_t feat6;
		word_t feat5;
		word_t feat4;
		word_t feat3;
		word_t feat2;
		word_t feat1;
		word_t feat0;
	} featureVec_t;

	typedef struct packed
	{
		word_t hid3;
		word_t hid2;
		word_t hid1;
		word_t hid0;
	} hiddenVec_t;

	typedef struct packed
	{
		word_t score2;
		word_t score1;
		word_t score0;
	} scoreVec_t;

	// hidden layer weights, indexed [neuron][feature].
	localparam word_t hiddenWeights [`MLP_HIDDEN][`MLP_FEATURES] = '{
		'{16'sd16, -16'sd10, -16'sd4, 16'sd13, 16'sd22,
			-16'sd24, 16'sd1, 16'sd12, 16'sd4, -16'sd1,
			-16'sd9, 16'sd10, -16'sd3, 16'sd18, 16'sd16},
		'{-16'sd7, 16'sd14, 16'sd9, -16'sd12, 16'sd3,
			16'sd8, -16'sd20, 16'sd5, 16'sd11, -16'sd6,
			16'sd17, -16'sd2, 16'sd7, -16'sd15, 16'sd2},
		'{16'sd5, 16'sd21, -16'sd13, -16'sd8, -16'sd16,
			16'sd2, 16'sd9, -16'sd4, -16'sd19, 16'sd14,
			16'sd6, 16'sd11, -16'sd1, 16'sd8, -16'sd11},
		'{-16'sd3, -16'sd5, 16'sd18, 16'sd7, -16'sd9,
			16'sd13, 16'sd4, -16'sd17, 16'sd6, 16'sd20,
			-16'sd12, -16'sd8, 16'sd15, 16'sd1, -16'sd6}
	};

	localparam word_t hiddenBias [`MLP_HIDDEN] = '{
		-16'sd1, 16'sd3, -16'sd4, 16'sd2
	};

	// output layer weights, indexed [class][hidden neuron].
	localparam word_t outputWeights [`MLP_CLASSES][`MLP_HIDDEN] = '{
		'{16'sd9, -16'sd6, 16'sd4, -16'sd3},
		'{-16'sd5, 16'sd11, -16'sd7, 16'sd8},
		'{16'sd3, 16'sd2, 16'sd10, -16'sd9}
	};

	localparam word_t outputBias [`MLP_CLASSES] = '{
		16'sd5, -16'sd2, 16'sd1
	};

	// packs one table row into the vector form a neuron takes as parameter.
	function automatic hiddenRow_t hiddenRow(input int n);
		hiddenRow_t row;
		for (int i = 0; i < `MLP_FEATURES; i++)
		begin
			row[i] = hiddenWeights[n][i];
		end
		return row;
	endfunction

	function automatic outputRow_t outputRow(input int n);
		outputRow_t row;
		for (int i = 0; i < `MLP_HIDDEN; i++)
		begin
			row[i] = outputWeights[n][i];
		end
		return row;
	endfunction

endpackage

// ==== src/neuron.sv ====
`timescale 1ns/1ns
`include "mlp_macros.svh"

module neuron #(
	parameter int INPUTS = 15,
	parameter mlpPkg::actFunc_t ACT = mlpPkg::actRelu,
	parameter mlpPkg::word_t [INPUTS-1:0] WEIGHTS = '0,
	parameter mlpPkg::word_t BIAS = '0
) (
	input logic clk,
	input logic reset,
	input mlpPkg::word_t [INPUTS-1:0] in,
	output mlpPkg::word_t out
);
	import mlpPkg::*;

	word_t [INPUTS-1:0] inReg;
	word_t [INPUTS-1:0] products;
	word_t sumNext;
	word_t sumReg;
	word_t actValue;

	// the first stage captures the inputs.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
		end
		else
		begin
			inReg <= in;
		end
	end

	// each product keeps only its low word.
	always_comb
	begin
		for (int i = 0; i < INPUTS; i++)
		begin
			products[i] = word_t'(inReg[i] * WEIGHTS[i]);
		end
	end

	// sum of products plus bias wraps on overflow.
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < INPUTS; i++)
		begin
			sumNext = word_t'(sumNext + products[i]);
		end
	end

	// the second stage registers the sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	// relu looks only at the sign bit of the wrapped sum.
	always_comb
	begin
		case (ACT)
			actRelu:
			begin
				if (sumReg[`MLP_WIDTH-1])
				begin
					actValue = '0;
				end
				else
				begin
					actValue = sumReg;
				end
			end
			actLinear:
			begin
				actValue = sumReg;
			end
		endcase
	end

	// the third stage registers the activation.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out <= '0;
		end
		else
		begin
			out <= actValue;
		end
	end

endmodule

// ==== src/classSelect.sv ====
`timescale 1ns/1ns
`include "mlp_macros.svh"

module classSelect (
	input logic clk,
	input logic reset,
	input mlpPkg::scoreVec_t scores,
	output mlpPkg::classIdx_t classIdx
);
	import mlpPkg::*;

	word_t [`MLP_CLASSES-1:0] scoreWords;
	word_t bestScore;
	classIdx_t bestIdx;

	assign scoreWords[0] = scores.score0;
	assign scoreWords[1] = scores.score1;
	assign scoreWords[2] = scores.score2;

	// scan from class 0 upward.
	// a strict compare leaves ties with the lower index.
	always_comb
	begin
		bestIdx = '0;
		bestScore = scoreWords[0];
		for (int c = 1; c < `MLP_CLASSES; c++)
		begin
			if ($signed(scoreWords[c]) > $signed(bestScore))
			begin
				bestIdx = classIdx_t'(c);
				bestScore = scoreWords[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIdx <= '0;
		end
		else
		begin
			classIdx <= bestIdx;
		end
	end

endmodule

// ==== src/mlpCore.sv ====
`timescale 1ns/1ns
`include "mlp_macros.svh"

module mlpCore (
	input logic clk,
	input logic reset,
	input mlpPkg::featureVec_t features,
	output mlpPkg::scoreVec_t scores,
	output mlpPkg::classIdx_t classIdx
);
	import mlpPkg::*;

	word_t [`MLP_FEATURES-1:0] featureWords;
	word_t [`MLP_HIDDEN-1:0] hiddenOut;
	hiddenVec_t hidden;
	word_t [`MLP_HIDDEN-1:0] hiddenWords;
	word_t [`MLP_CLASSES-1:0] scoreOut;

	// feature fields in input order.
	assign featureWords[0] = features.feat0;
	assign featureWords[1] = features.feat1;
	assign featureWords[2] = features.feat2;
	assign featureWords[3] = features.feat3;
	assign featureWords[4] = features.feat4;
	assign featureWords[5] = features.feat5;
	assign featureWords[6] = features.feat6;
	assign featureWords[7] = features.feat7;
	assign featureWords[8] = features.feat8;
	assign featureWords[9] = features.feat9;
	assign featureWords[10] = features.feat10;
	assign featureWords[11] = features.feat11;
	assign featureWords[12] = features.feat12;
	assign featureWords[13] = features.feat13;
	assign featureWords[14] = features.feat14;

	// hidden layer, every neuron sees the whole feature vector.
	generate
		for (genvar n = 0; n < `MLP_HIDDEN; n++)
		begin : hiddenLayer
			neuron #(
				.INPUTS(`MLP_FEATURES),
				.ACT(actRelu),
				.WEIGHTS(hiddenRow(n)),
				.BIAS(hiddenBias[n])
			) hiddenNeuron_i (
				.clk(clk),
				.reset(reset),
				.in(featureWords),
				.out(hiddenOut[n])
			);
		end
	endgenerate

	assign hidden.hid0 = hiddenOut[0];
	assign hidden.hid1 = hiddenOut[1];
	assign hidden.hid2 = hiddenOut[2];
	assign hidden.hid3 = hiddenOut[3];

	assign hiddenWords[0] = hidden.hid0;
	assign hiddenWords[1] = hidden.hid1;
	assign hiddenWords[2] = hidden.hid2;
	assign hiddenWords[3] = hidden.hid3;

	// output layer is linear so scores may go negative.
	generate
		for (genvar n = 0; n < `MLP_CLASSES; n++)
		begin : outputLayer
			neuron #(
				.INPUTS(`MLP_HIDDEN),
				.ACT(actLinear),
				.WEIGHTS(outputRow(n)),
				.BIAS(outputBias[n])
			) outputNeuron_i (
				.clk(clk),
				.reset(reset),
				.in(hiddenWords),
				.out(scoreOut[n])
			);
		end
	endgenerate

	// scores leave straight from the output neuron registers.
	assign scores.score0 = scoreOut[0];
	assign scores.score1 = scoreOut[1];
	assign scores.score2 = scoreOut[2];

	classSelect classSelect_i (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIdx(classIdx)
	);

endmodule

// ==== dv/mlpModel.svh ====
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// hidden layer, each product keeps its low word and the sum wraps at 16 bits.
function automatic hiddenVec_t hiddenRef(input featureVec_t f);
	hiddenVec_t h;
	word_t x;
	int acc;
	h = '0;
	for (int n = 0; n < `MLP_HIDDEN; n++)
	begin
		acc = int'(hiddenBias[n]) & 32'hFFFF;
		for (int i = 0; i < `MLP_FEATURES; i++)
		begin
			x = f[i*`MLP_WIDTH +: `MLP_WIDTH];
			acc = (acc + ((int'(x) * int'(hiddenWeights[n][i])) & 32'hFFFF)) & 32'hFFFF;
		end
		// bit 15 set reads as a negative sum.
		if (acc[15])
		begin
			acc = 0;
		end
		h[n*`MLP_WIDTH +: `MLP_WIDTH] = acc[15:0];
	end
	return h;
endfunction

// output layer is linear.
function automatic scoreVec_t scoresRef(input hiddenVec_t h);
	scoreVec_t s;
	word_t x;
	int acc;
	s = '0;
	for (int c = 0; c < `MLP_CLASSES; c++)
	begin
		acc = int'(outputBias[c]) & 32'hFFFF;
		for (int n = 0; n < `MLP_HIDDEN; n++)
		begin
			x = h[n*`MLP_WIDTH +: `MLP_WIDTH];
			acc = (acc + ((int'(x) * int'(outputWeights[c][n])) & 32'hFFFF)) & 32'hFFFF;
		end
		s[c*`MLP_WIDTH +: `MLP_WIDTH] = acc[15:0];
	end
	return s;
endfunction

// largest signed score wins, the first one found keeps a tie.
function automatic classIdx_t classRef(input scoreVec_t s);
	classIdx_t best;
	word_t bestVal;
	word_t v;
	best = '0;
	bestVal = s[0 +: `MLP_WIDTH];
	for (int c = 1; c < `MLP_CLASSES; c++)
	begin
		v = s[c*`MLP_WIDTH +: `MLP_WIDTH];
		if (v > bestVal)
		begin
			best = classIdx_t'(c);
			bestVal = v;
		end
	end
	return best;
endfunction

`endif

// ==== dv/mlpCoreTb.sv ====
`timescale 1ns/1ns
`include "mlp_macros.svh"

module mlpCoreTb;
	import mlpPkg::*;

	`include "mlpModel.svh"

	typedef struct packed
	{
		int seq;
		featureVec_t feat;
	} entry_t;

	logic clk;
	logic reset;
	featureVec_t features;
	scoreVec_t scores;
	classIdx_t classIdx;

	// delay lines, one entry per applied vector.
	entry_t scoreLine[$];
	entry_t classLine[$];
	int seed = 32'h2c605f44;
	int nextSeq = 0;
	int lastClassSeq = -1;
	int checks = 0;
	int errors = 0;
	int testStart = 0;
	bit lastRst = 1'b0;
	bit prevRst = 1'b0;
	word_t extremes [5] = '{16'h7FFF, 16'h8000, 16'h0001, 16'hFFFF, 16'h4000};

	mlpCore mlpCore_i (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classIdx(classIdx)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic featureVec_t randomVector(input bit extreme);
		featureVec_t f;
		for (int i = 0; i < `MLP_FEATURES; i++)
		begin
			if (extreme)
			begin
				f[i*`MLP_WIDTH +: `MLP_WIDTH] = extremes[$unsigned($random(seed)) % 5];
			end
			else
			begin
				f[i*`MLP_WIDTH +: `MLP_WIDTH] = 16'($random(seed));
			end
		end
		return f;
	endfunction

	// reset flushes the pipeline, so its delay lines are emptied too.
	task automatic stepCycle(input featureVec_t f, input logic rst);
		entry_t e;
		@(posedge clk);
		#2;
		reset = rst;
		features = f;
		if (rst)
		begin
			scoreLine.delete();
			classLine.delete();
		end
		else
		begin
			e.seq = nextSeq;
			e.feat = f;
			scoreLine.push_back(e);
			classLine.push_back(e);
			nextSeq++;
		end
	endtask

	task automatic holdReset();
		for (int k = 0; k < 10; k++)
		begin
			stepCycle(randomVector(1'b0), 1'b1);
		end
	endtask

	// zero vectors keep the pipeline moving until the last class is out.
	task automatic finishTest(input string name);
		int target;
		int waited;
		target = nextSeq - 1;
		waited = 0;
		while (lastClassSeq < target && waited < 20)
		begin
			stepCycle('0, 1'b0);
			waited++;
		end
		if (lastClassSeq < target)
		begin
			$display("test %s: timed out waiting for its last result", name);
			errors++;
		end
		$display("test %s done, %0d errors", name, errors - testStart);
		testStart = errors;
	endtask

	task automatic checkScores(input scoreVec_t expected, input scoreVec_t actual);
		word_t expWord;
		word_t actWord;
		for (int c = 0; c < `MLP_CLASSES; c++)
		begin
			expWord = expected[c*`MLP_WIDTH +: `MLP_WIDTH];
			actWord = actual[c*`MLP_WIDTH +: `MLP_WIDTH];
			checks++;
			if (actWord !== expWord)
			begin
				errors++;
				$display("CHECK FAILED scores.score%0d (class %0d): expected %h actual %h",
					c, c, expWord, actWord);
			end
		end
	endtask

	task automatic checkClass(input classIdx_t expected, input classIdx_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED classIdx: expected %h actual %h", expected, actual);
		end
	endtask

	always @(posedge clk)
	begin
		prevRst <= lastRst;
		lastRst <= reset;
	end

	// outputs are stable at the falling edge.
	always @(negedge clk)
	begin : compare
		entry_t e;
		if (lastRst || prevRst)
		begin
			checkScores('0, scores);
			checkClass('0, classIdx);
		end
		if (scoreLine.size() > 6)
		begin
			e = scoreLine.pop_front();
			checkScores(scoresRef(hiddenRef(e.feat)), scores);
		end
		if (classLine.size() > 7)
		begin
			e = classLine.pop_front();
			checkClass(classRef(scoresRef(hiddenRef(e.feat))), classIdx);
			lastClassSeq = e.seq;
		end
	end

	initial
	begin : main
		featureVec_t f;
		reset = 1'b1;
		features = '0;
		holdReset();
		for (int k = 0; k < 4; k++)
		begin
			stepCycle('0, 1'b0);
		end
		finishTest("zero features");
		for (int i = 0; i < `MLP_FEATURES; i++)
		begin
			f = '0;
			f[i*`MLP_WIDTH +: `MLP_WIDTH] = 16'd1;
			stepCycle(f, 1'b0);
		end
		finishTest("one-hot features");
		for (int k = 0; k < 200; k++)
		begin
			stepCycle(randomVector(1'b0), 1'b0);
		end
		finishTest("random stream");
		stepCycle({`MLP_FEATURES{16'h7FFF}}, 1'b0);
		stepCycle({`MLP_FEATURES{16'h8000}}, 1'b0);
		for (int k = 0; k < 40; k++)
		begin
			stepCycle(randomVector(1'b1), 1'b0);
		end
		finishTest("wraparound");
		for (int k = 0; k < 20; k++)
		begin
			stepCycle(randomVector(1'b0), 1'b0);
		end
		holdReset();
		for (int k = 0; k < 20; k++)
		begin
			stepCycle(randomVector(1'b0), 1'b0);
		end
		finishTest("reset mid-stream");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+src
+incdir+dv
src/mlpPkg.sv
src/neuron.sv
src/classSelect.sv
src/mlpCore.sv
dv/mlpCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the mlpCore testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f build.f --top-module mlpCoreTb -o mlpCoreSim

./obj_dir/mlpCoreSim | tee sim.log

if grep -q "Errors found" sim.log
then
	echo "simulation FAILED"
	exit 1
fi

echo "simulation passed"
